// ==== bench/mlu_asserts.sv ====
// Protocol checks on the arithmetic unit ports, bound into the top level by the testbench
`timescale 1ns/1ps
`default_nettype none

module mlu_asserts #(
    parameter int QUEUE_DEPTH = 8
) (
    input logic                         clk_i,
    input logic                         rstn_i,
    input logic                         flush_i,
    input logic                         in_ready_i,
    input logic [$clog2(QUEUE_DEPTH):0] count_i,  // Queue occupancy
    input logic                         out_valid_i,
    input logic                         out_ready_i,
    input logic [mlu_pkg::RD_W-1:0]     out_rd_i,
    input logic [mlu_pkg::DATA_W-1:0]   out_data_i,
    input mlu_pkg::status_t             out_status_i
);
    int fail_count = 0;  // Failed checks so far

    // Stalled output keeps valid and payload
    out_hold_a: assert property (@(posedge clk_i) disable iff (!rstn_i || flush_i)
        out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_data_i)
                                        && $stable(out_rd_i) && $stable(out_status_i))
    else begin
        fail_count++;
        $error("output dropped or changed while stalled");
    end

    // Every entry taken means no new input
    full_block_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        count_i == QUEUE_DEPTH |-> !in_ready_i)
    else begin
        fail_count++;
        $error("input ready while queue full");
    end

    flush_clear_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        flush_i |=> !out_valid_i)  // Output register cleared by flush
    else begin
        fail_count++;
        $error("output valid right after flush");
    end

    count_max_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        count_i <= QUEUE_DEPTH)
    else begin
        fail_count++;
        $error("queue count above depth");
    end

endmodule

`default_nettype wire

// ==== bench/mlu_tb.sv ====
// Self-checking testbench driving random instructions into the arithmetic unit
`timescale 1ns/1ps
`default_nettype none

module mlu_tb;
    import mlu_pkg::*;

    localparam int QUEUE_DEPTH = 8;
    localparam int N_INSTR     = 2000;   // Accepted instructions before drain
    localparam int WAIT_LIMIT  = 400;    // Longest single stall allowed
    localparam int RUN_LIMIT   = 50000;  // Whole stimulus phase
    localparam int DRAIN_LIMIT = 2000;

    logic              clk       = 1'b0;
    logic              rstn      = 1'b0;
    logic              flush     = 1'b0;
    logic              in_valid  = 1'b0;
    instr_word_u       in_word   = '0;
    logic [DATA_W-1:0] in_a      = '0;
    logic [DATA_W-1:0] in_b      = '0;
    logic [DATA_W-1:0] in_c      = '0;
    logic              out_ready = 1'b0;
    logic              in_ready;
    logic              out_valid;
    logic [RD_W-1:0]   out_rd;
    logic [DATA_W-1:0] out_data;
    status_t           out_status;

    logic [31:0]       rng_state = 32'h374e_a7c4;
    int                n_acc     = 0;  // Instructions taken by the DUT
    int                gap_left  = 0;  // Remaining cycles of an output stall
    int                wait_in   = 0;
    int                wait_out  = 0;

    // Expected results in program order
    logic [RD_W-1:0]   exp_rd_q     [$];
    logic [DATA_W-1:0] exp_data_q   [$];
    status_t           exp_status_q [$];
    string             exp_name_q   [$];

    always #50 clk = ~clk;  // 100 ns period

    mlu_top #(.QUEUE_DEPTH(QUEUE_DEPTH)) mlu_top_i (
        .clk_i(clk), .rstn_i(rstn), .flush_i(flush),
        .in_valid_i(in_valid), .in_word_i(in_word),
        .in_a_i(in_a), .in_b_i(in_b), .in_c_i(in_c), .in_ready_o(in_ready),
        .out_valid_o(out_valid), .out_rd_o(out_rd), .out_data_o(out_data),
        .out_status_o(out_status), .out_ready_i(out_ready)
    );

    bind mlu_top mlu_asserts #(.QUEUE_DEPTH(QUEUE_DEPTH)) mlu_asserts_i (
        .clk_i, .rstn_i, .flush_i, .in_ready_i(in_ready_o),
        .count_i(pending_ops_queue_i.count_q), .out_valid_i(out_valid_o), .out_ready_i,
        .out_rd_i(out_rd_o), .out_data_i(out_data_o), .out_status_i(out_status_o)
    );

    function automatic logic [31:0] xorshift32();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // Mix of edge values and random words
    function automatic logic [DATA_W-1:0] pick_operand();
        logic [31:0] r;
        r = xorshift32();
        case (r[2:0])
            3'd0:    return '0;
            3'd1:    return {{28{r[31]}}, r[30:27]};  // Small signed
            3'd2:    return 32'h7fff_ffff;
            3'd3:    return 32'h8000_0000;
            3'd4:    return {{16{r[31]}}, r[30:15]};  // Mid range so mul mostly fits
            default: return xorshift32();
        endcase
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                              input logic [DATA_W-1:0] act);
        if (act !== exp)
            report_failure($sformatf("[FAIL] %s data expected %h actual %h", name, exp, act));
    endtask

    task automatic check_rd(input string name, input logic [RD_W-1:0] exp,
                            input logic [RD_W-1:0] act);
        if (act !== exp)
            report_failure($sformatf("[FAIL] %s rd expected %0d actual %0d", name, exp, act));
    endtask

    task automatic check_status(input string name, input status_t exp, input status_t act);
        if (act !== exp)
            report_failure($sformatf("[FAIL] %s status expected %b actual %b", name, exp, act));
    endtask

    // Reference model with 64-bit signed arithmetic
    task automatic compute_expected(input instr_word_u w, input logic [DATA_W-1:0] a, b, c,
                                    output logic [DATA_W-1:0] data, output status_t st,
                                    output string op);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] sc;
        logic signed [63:0] full;
        logic               legal;
        sa    = {{32{a[31]}}, a};
        sb    = {{32{b[31]}}, b};
        sc    = {{32{c[31]}}, c};
        full  = '0;
        legal = 1'b1;
        if (w.r.opcode == OPC_ARITH) begin
            case (w.r.funct)
                FN_ADD: begin
                    full = sa + sb;
                    op   = "add";
                end
                FN_SUB: begin
                    full = sa - sb;
                    op   = "sub";
                end
                FN_MIN: begin
                    full = (sa < sb) ? sa : sb;
                    op   = "min";
                end
                FN_MAX: begin
                    full = (sa < sb) ? sb : sa;
                    op   = "max";
                end
                FN_MUL: begin
                    full = sa * sb;
                    op   = "mul";
                end
                default: begin
                    legal = 1'b0;
                    op    = "illegal funct";
                end
            endcase
        end else if (w.r4.opcode == OPC_MADD) begin
            full = w.r4.neg_c ? sa * sb - sc : sa * sb + sc;  // Never leaves 64 bits
            op   = w.r4.neg_c ? "msub" : "madd";
        end else begin
            legal = 1'b0;
            op    = "illegal opcode";
        end
        if (legal) begin
            data = full[31:0];
            st   = '{overflow: (full != {{32{full[31]}}, full[31:0]}),
                     zero:     (full[31:0] == '0),
                     illegal:  1'b0};
        end else begin
            data = '0;
            st   = '{overflow: 1'b0, zero: 1'b0, illegal: 1'b1};
        end
    endtask

    task automatic make_instr(output instr_word_u w);
        int unsigned kind;
        w    = xorshift32();  // Random rd, reserved bits and neg_c
        kind = xorshift32() % 20;
        if (kind < 11) begin
            w.r.opcode = OPC_ARITH;
            w.r.funct  = 3'(xorshift32() % 5);
        end else if (kind < 13) begin
            w.r.opcode = OPC_ARITH;
            w.r.funct  = 3'(5 + xorshift32() % 3);  // Undefined codes
        end else if (kind < 19) begin
            w.r4.opcode = OPC_MADD;
        end
        // Kind 19 keeps a random opcode
    endtask

    task automatic record_input();
        logic [DATA_W-1:0] data;
        status_t           st;
        string             op;
        compute_expected(in_word, in_a, in_b, in_c, data, st, op);
        exp_rd_q.push_back(in_word.r.rd);  // Same slot in both views
        exp_data_q.push_back(data);
        exp_status_q.push_back(st);
        exp_name_q.push_back($sformatf("instr %0d %s", n_acc, op));
        n_acc++;
    endtask

    task automatic check_output();
        string name;
        if (exp_data_q.size() == 0) begin
            report_failure("the DUT gave an output with no instruction pending");
        end else begin
            name = exp_name_q.pop_front();
            check_rd(name, exp_rd_q.pop_front(), out_rd);
            check_data(name, exp_data_q.pop_front(), out_data);
            check_status(name, exp_status_q.pop_front(), out_status);
        end
    endtask

    task automatic drive_next(input logic in_fire);
        instr_word_u       w;
        logic [DATA_W-1:0] a;
        if (gap_left > 0) begin
            gap_left--;
            out_ready <= 1'b0;
        end else if (xorshift32() % 64 == 0) begin
            gap_left = 20 + int'(xorshift32() % 30);  // Long stall lets the queue fill
            out_ready <= 1'b0;
        end else begin
            out_ready <= (xorshift32() % 4) != 0;
        end
        flush <= 1'b0;
        if (in_fire && xorshift32() % 200 == 0) begin
            flush     <= 1'b1;  // One-cycle flush
            out_ready <= 1'b0;  // No drain in the flush edge
        end
        if (n_acc >= N_INSTR) begin
            in_valid <= 1'b0;
        end else if (in_fire || !in_valid) begin
            if (xorshift32() % 4 == 0) begin
                in_valid <= 1'b0;  // Input gap
            end else begin
                make_instr(w);
                a = pick_operand();
                in_valid <= 1'b1;
                in_word  <= w;
                in_a     <= a;
                in_b     <= (xorshift32() % 8 == 0) ? a : pick_operand();  // Equal pair for zero
                in_c     <= pick_operand();
            end
        end
        // Else held until taken
    endtask

    // One clock edge of traffic
    task automatic step();
        logic in_fire;
        logic out_fire;
        @(posedge clk);
        if (mlu_top_i.mlu_asserts_i.fail_count != 0)
            report_failure("a protocol assertion on the DUT ports failed");
        in_fire  = in_valid & in_ready;
        out_fire = out_valid & out_ready;
        if (out_fire) check_output();
        if (flush) begin
            exp_rd_q.delete();  // Everything in flight is killed
            exp_data_q.delete();
            exp_status_q.delete();
            exp_name_q.delete();
        end
        if (in_fire) record_input();
        if (exp_data_q.size() > QUEUE_DEPTH + 1)
            report_failure("the DUT accepted more instructions than it can hold");
        wait_in  = (in_valid && !in_fire) ? wait_in + 1 : 0;
        wait_out = (exp_data_q.size() != 0 && !out_fire) ? wait_out + 1 : 0;
        if (wait_in > WAIT_LIMIT)
            report_failure("timeout waiting for the DUT to accept an instruction");
        if (wait_out > WAIT_LIMIT)
            report_failure("timeout waiting for an expected result at the output");
        drive_next(in_fire);
    endtask

    initial begin
        int cycles;
        cycles = 0;
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        while (n_acc < N_INSTR) begin
            step();
            cycles++;
            if (cycles > RUN_LIMIT)
                report_failure("timeout before all instructions were accepted");
        end
        cycles = 0;
        while (exp_data_q.size() != 0) begin
            step();
            cycles++;
            if (cycles > DRAIN_LIMIT)
                report_failure("timeout draining the pending results");
        end
        repeat (20) step();  // Stray outputs would find an empty model
        if (mlu_top_i.mlu_asserts_i.fail_count != 0) begin
            report_failure("a protocol assertion failed during the run");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/exec_pipes.sv ====
// Short and long integer pipes of the arithmetic unit, merged onto one tagged result port
`timescale 1ns/1ps
`default_nettype none

module exec_pipes #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                           clk_i,
    input  logic                           rstn_i,
    input  logic                           flush_i,
    input  logic                           iss_valid_i,
    input  mlu_pkg::exec_op_e              iss_op_i,
    input  logic [$clog2(QUEUE_DEPTH)-1:0] iss_tag_i,
    input  logic [mlu_pkg::DATA_W-1:0]     iss_a_i,
    input  logic [mlu_pkg::DATA_W-1:0]     iss_b_i,
    input  logic [mlu_pkg::DATA_W-1:0]     iss_c_i,
    output logic                           res_valid_o,
    output logic [$clog2(QUEUE_DEPTH)-1:0] res_tag_o,
    output logic [mlu_pkg::DATA_W-1:0]     res_data_o,
    output mlu_pkg::status_t               res_status_o
);
    import mlu_pkg::*;

    localparam int TAG_W = $clog2(QUEUE_DEPTH);
    localparam int ACC_W = 2*DATA_W + 2;  // Product plus c never overflows this

    logic              iss_short;
    logic [DATA_W:0]   s_sum;  // One guard bit for overflow
    logic [DATA_W-1:0] s_res;
    logic              s_lt;
    logic              s_ovf;
    logic              s_valid_q;
    logic [TAG_W-1:0]  s_tag_q;
    logic [DATA_W-1:0] s_data_q;
    status_t           s_status_q;

    logic [LONG_LAT-1:0]        l_valid_q;  // Valid and tag ride a plain shift
    logic [TAG_W-1:0]           l_tag_q [LONG_LAT];
    logic signed [2*DATA_W-1:0] l_prod_q;
    logic [DATA_W-1:0]          l_c_q;
    exec_op_e                   l_op_q;
    logic [ACC_W-1:0]           l_acc;
    logic [ACC_W-1:0]           l_acc_q;
    logic [DATA_W-1:0]          l_data_q;
    status_t                    l_status_q;

    assign iss_short = iss_op_i inside {OP_ADD, OP_SUB, OP_MIN, OP_MAX};

    always_comb begin
        if (iss_op_i == OP_SUB) s_sum = {iss_a_i[DATA_W-1], iss_a_i} - {iss_b_i[DATA_W-1], iss_b_i};
        else                    s_sum = {iss_a_i[DATA_W-1], iss_a_i} + {iss_b_i[DATA_W-1], iss_b_i};
        s_lt = $signed(iss_a_i) < $signed(iss_b_i);
        case (iss_op_i)
            OP_MIN:  s_res = s_lt ? iss_a_i : iss_b_i;
            OP_MAX:  s_res = s_lt ? iss_b_i : iss_a_i;
            default: s_res = s_sum[DATA_W-1:0];
        endcase
        // Guard and sign bits disagree on wrap, min/max never overflow
        s_ovf = (iss_op_i inside {OP_ADD, OP_SUB}) & (s_sum[DATA_W] ^ s_sum[DATA_W-1]);
    end

    // Stage 2 of long pipe, add or subtract c on the full product
    always_comb begin
        case (l_op_q)
            OP_MADD: l_acc = {{2{l_prod_q[2*DATA_W-1]}}, l_prod_q}
                           + {{(DATA_W+2){l_c_q[DATA_W-1]}}, l_c_q};
            OP_MSUB: l_acc = {{2{l_prod_q[2*DATA_W-1]}}, l_prod_q}
                           - {{(DATA_W+2){l_c_q[DATA_W-1]}}, l_c_q};
            default: l_acc = {{2{l_prod_q[2*DATA_W-1]}}, l_prod_q};  // Plain mul
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            s_valid_q <= 1'b0;
            l_valid_q <= '0;
        end else if (flush_i) begin
            s_valid_q <= 1'b0;  // Kill everything in flight
            l_valid_q <= '0;
        end else begin
            s_valid_q <= iss_valid_i & iss_short;
            l_valid_q <= {l_valid_q[LONG_LAT-2:0], iss_valid_i & ~iss_short};
        end
    end

    always_ff @(posedge clk_i) begin
        s_tag_q    <= iss_tag_i;
        s_data_q   <= s_res;
        s_status_q <= '{overflow: s_ovf, zero: (s_res == '0), illegal: 1'b0};
        l_tag_q[0] <= iss_tag_i;
        for (int i = 1; i < LONG_LAT; i++) begin
            l_tag_q[i] <= l_tag_q[i-1];
        end
        l_prod_q   <= $signed(iss_a_i) * $signed(iss_b_i);  // Stage 1
        l_c_q      <= iss_c_i;
        l_op_q     <= iss_op_i;
        l_acc_q    <= l_acc;                                // Stage 2
        l_data_q   <= l_acc_q[DATA_W-1:0];                  // Stage 3
        // Fits only if all upper bits copy bit 31
        l_status_q <= '{overflow: ~(&l_acc_q[ACC_W-1:DATA_W-1] | ~|l_acc_q[ACC_W-1:DATA_W-1]),
                        zero:     (l_acc_q[DATA_W-1:0] == '0),
                        illegal:  1'b0};
    end

    // Decoder keeps both pipes from finishing in one cycle
    assign res_valid_o  = s_valid_q | l_valid_q[LONG_LAT-1];
    assign res_tag_o    = l_valid_q[LONG_LAT-1] ? l_tag_q[LONG_LAT-1] : s_tag_q;
    assign res_data_o   = l_valid_q[LONG_LAT-1] ? l_data_q : s_data_q;
    assign res_status_o = l_valid_q[LONG_LAT-1] ? l_status_q : s_status_q;

endmodule

`default_nettype wire

// ==== hdl/mlu_pkg.sv ====
// Types and constants shared by all arithmetic unit RTL, compiled ahead of every module
`default_nettype none

package mlu_pkg;

    localparam int DATA_W   = 32;  // Operand and result width
    localparam int RD_W     = 5;   // Destination register index
    localparam int LONG_LAT = 3;   // Long pipe register stages

    // Major opcodes, bits [31:25] of the word
    typedef enum logic [6:0] {
        OPC_ARITH = 7'b0110011,  // Register-register format
        OPC_MADD  = 7'b1000011   // Fused multiply-add format
    } opcode_e;

    // Function codes, register-register only
    typedef enum logic [2:0] {
        FN_ADD = 3'd0,
        FN_SUB = 3'd1,
        FN_MIN = 3'd2,
        FN_MAX = 3'd3,
        FN_MUL = 3'd4   // Long pipe, codes 5..7 illegal
    } funct_e;

    typedef struct packed {
        logic [6:0]      opcode;
        logic [RD_W-1:0] rd;
        logic [2:0]      funct;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [6:0]      reserved;
    } r_fmt_t;

    typedef struct packed {
        logic [6:0]      opcode;  // Same slot as r_fmt_t
        logic [RD_W-1:0] rd;      // Same slot as r_fmt_t
        logic [4:0]      rs3;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic            neg_c;   // Subtract c instead of adding
        logic [3:0]      reserved;
    } r4_fmt_t;

    // One word, two views picked by opcode
    typedef union packed {
        r_fmt_t  r;
        r4_fmt_t r4;
    } instr_word_u;

    // Internal op selector handed to the pipes
    typedef enum logic [2:0] {
        OP_ADD, OP_SUB, OP_MIN, OP_MAX, OP_MUL, OP_MADD, OP_MSUB
    } exec_op_e;

    typedef struct packed {
        logic overflow;  // Signed result did not fit
        logic zero;      // Low 32 bits are zero
        logic illegal;   // Word not decodable
    } status_t;

endpackage

`default_nettype wire

// ==== hdl/mlu_top.sv ====
// Top of the multi-latency arithmetic unit, wiring decoder, pipes, queue and writeback
`timescale 1ns/1ps
`default_nettype none

module mlu_top #(
    parameter int QUEUE_DEPTH = 8  // Power of two, at least 4
) (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic                       flush_i,
    input  logic                       in_valid_i,
    input  mlu_pkg::instr_word_u       in_word_i,
    input  logic [mlu_pkg::DATA_W-1:0] in_a_i,
    input  logic [mlu_pkg::DATA_W-1:0] in_b_i,
    input  logic [mlu_pkg::DATA_W-1:0] in_c_i,
    output logic                       in_ready_o,
    output logic                       out_valid_o,
    output logic [mlu_pkg::RD_W-1:0]   out_rd_o,
    output logic [mlu_pkg::DATA_W-1:0] out_data_o,
    output mlu_pkg::status_t           out_status_o,
    input  logic                       out_ready_i
);
    import mlu_pkg::*;

    localparam int TAG_W = $clog2(QUEUE_DEPTH);

    logic              alloc, alloc_illegal, full, advance_head;
    logic [RD_W-1:0]   alloc_rd;
    logic [TAG_W-1:0]  tail_tag;
    logic              iss_valid;  // Decoder to pipes
    exec_op_e          iss_op;
    logic [TAG_W-1:0]  iss_tag;
    logic [DATA_W-1:0] iss_a, iss_b, iss_c;
    logic              res_valid;  // Pipes to queue
    logic [TAG_W-1:0]  res_tag;
    logic [DATA_W-1:0] res_data;
    status_t           res_status;
    logic              head_done;  // Queue to writeback
    logic [RD_W-1:0]   head_rd;
    logic [DATA_W-1:0] head_data;
    status_t           head_status;

    op_decoder #(.QUEUE_DEPTH(QUEUE_DEPTH)) op_decoder_i (
        .clk_i, .rstn_i, .flush_i, .in_valid_i, .in_word_i, .in_a_i, .in_b_i, .in_c_i,
        .full_i(full), .tail_tag_i(tail_tag), .in_ready_o, .alloc_o(alloc),
        .alloc_rd_o(alloc_rd), .alloc_illegal_o(alloc_illegal), .iss_valid_o(iss_valid),
        .iss_op_o(iss_op), .iss_tag_o(iss_tag), .iss_a_o(iss_a), .iss_b_o(iss_b), .iss_c_o(iss_c)
    );

    exec_pipes #(.QUEUE_DEPTH(QUEUE_DEPTH)) exec_pipes_i (
        .clk_i, .rstn_i, .flush_i, .iss_valid_i(iss_valid), .iss_op_i(iss_op),
        .iss_tag_i(iss_tag), .iss_a_i(iss_a), .iss_b_i(iss_b), .iss_c_i(iss_c),
        .res_valid_o(res_valid), .res_tag_o(res_tag), .res_data_o(res_data),
        .res_status_o(res_status)
    );

    pending_ops_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) pending_ops_queue_i (
        .clk_i, .rstn_i, .flush_i, .alloc_i(alloc), .alloc_rd_i(alloc_rd),
        .alloc_illegal_i(alloc_illegal), .res_valid_i(res_valid), .res_tag_i(res_tag),
        .res_data_i(res_data), .res_status_i(res_status), .advance_head_i(advance_head),
        .tail_tag_o(tail_tag), .full_o(full), .head_done_o(head_done), .head_rd_o(head_rd),
        .head_data_o(head_data), .head_status_o(head_status)
    );

    writeback_stage writeback_stage_i (
        .clk_i, .rstn_i, .flush_i, .head_done_i(head_done), .head_rd_i(head_rd),
        .head_data_i(head_data), .head_status_i(head_status), .out_ready_i,
        .advance_head_o(advance_head), .out_valid_o, .out_rd_o, .out_data_o, .out_status_o
    );

endmodule

`default_nettype wire

// ==== hdl/op_decoder.sv ====
// Input stage of the arithmetic unit: decodes words, allocates queue tags and issues to pipes
`timescale 1ns/1ps
`default_nettype none

module op_decoder #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                           clk_i,
    input  logic                           rstn_i,
    input  logic                           flush_i,
    input  logic                           in_valid_i,
    input  mlu_pkg::instr_word_u           in_word_i,
    input  logic [mlu_pkg::DATA_W-1:0]     in_a_i,
    input  logic [mlu_pkg::DATA_W-1:0]     in_b_i,
    input  logic [mlu_pkg::DATA_W-1:0]     in_c_i,
    input  logic                           full_i,      // Queue has no free entry
    input  logic [$clog2(QUEUE_DEPTH)-1:0] tail_tag_i,  // Tag for the next allocation
    output logic                           in_ready_o,
    output logic                           alloc_o,
    output logic [mlu_pkg::RD_W-1:0]       alloc_rd_o,
    output logic                           alloc_illegal_o,
    output logic                           iss_valid_o,
    output mlu_pkg::exec_op_e              iss_op_o,
    output logic [$clog2(QUEUE_DEPTH)-1:0] iss_tag_o,
    output logic [mlu_pkg::DATA_W-1:0]     iss_a_o,
    output logic [mlu_pkg::DATA_W-1:0]     iss_b_o,
    output logic [mlu_pkg::DATA_W-1:0]     iss_c_o
);
    import mlu_pkg::*;

    exec_op_e            dec_op;
    logic                dec_illegal;
    logic                dec_long;
    logic                dec_short;
    logic [LONG_LAT-1:0] long_occ_q;  // Bit i: long result lands i+1 cycles ahead
    logic [1:0]          boot_q;      // Ready held off after reset release

    always_comb begin
        dec_op      = OP_ADD;
        dec_illegal = 1'b0;
        case (in_word_i.r.opcode)
            OPC_ARITH: begin
                case (in_word_i.r.funct)
                    FN_ADD:  dec_op = OP_ADD;
                    FN_SUB:  dec_op = OP_SUB;
                    FN_MIN:  dec_op = OP_MIN;
                    FN_MAX:  dec_op = OP_MAX;
                    FN_MUL:  dec_op = OP_MUL;
                    default: dec_illegal = 1'b1;
                endcase
            end
            OPC_MADD: dec_op = in_word_i.r4.neg_c ? OP_MSUB : OP_MADD;  // Fused view
            default:  dec_illegal = 1'b1;
        endcase
    end

    assign dec_long  = ~dec_illegal & (dec_op inside {OP_MUL, OP_MADD, OP_MSUB});
    assign dec_short = ~dec_illegal & ~dec_long;

    // Short op now would share the result port with a long op taken 2 cycles ago
    assign in_ready_o = boot_q[1] & ~full_i & ~flush_i & ~(dec_short & long_occ_q[1]);
    assign alloc_o         = in_valid_i & in_ready_o;
    assign alloc_rd_o      = in_word_i.r.rd;  // Same slot in both views
    assign alloc_illegal_o = dec_illegal;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            boot_q      <= '0;
            long_occ_q  <= '0;
            iss_valid_o <= 1'b0;
        end else begin
            boot_q <= {boot_q[0], 1'b1};
            if (flush_i) begin
                long_occ_q  <= '0;  // Pipes are emptied too
                iss_valid_o <= 1'b0;
            end else begin
                long_occ_q  <= {alloc_o & dec_long, long_occ_q[LONG_LAT-1:1]};
                iss_valid_o <= alloc_o & ~dec_illegal;  // Illegal never issues
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_o) begin
            iss_op_o  <= dec_op;
            iss_tag_o <= tail_tag_i;
            iss_a_o   <= in_a_i;
            iss_b_o   <= in_b_i;
            iss_c_o   <= in_c_i;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pending_ops_queue.sv ====
// In-flight table of the arithmetic unit, filled out of order by tag and drained in order at head
`timescale 1ns/1ps
`default_nettype none

module pending_ops_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                           clk_i,
    input  logic                           rstn_i,
    input  logic                           flush_i,
    input  logic                           alloc_i,          // New entry at tail
    input  logic [mlu_pkg::RD_W-1:0]       alloc_rd_i,
    input  logic                           alloc_illegal_i,  // Entry done at once
    input  logic                           res_valid_i,
    input  logic [$clog2(QUEUE_DEPTH)-1:0] res_tag_i,
    input  logic [mlu_pkg::DATA_W-1:0]     res_data_i,
    input  mlu_pkg::status_t               res_status_i,
    input  logic                           advance_head_i,   // Head taken by writeback
    output logic [$clog2(QUEUE_DEPTH)-1:0] tail_tag_o,
    output logic                           full_o,
    output logic                           head_done_o,
    output logic [mlu_pkg::RD_W-1:0]       head_rd_o,
    output logic [mlu_pkg::DATA_W-1:0]     head_data_o,
    output mlu_pkg::status_t               head_status_o
);
    import mlu_pkg::*;

    localparam int TAG_W = $clog2(QUEUE_DEPTH);

    logic [TAG_W-1:0]       head_q;   // Oldest entry
    logic [TAG_W-1:0]       tail_q;   // Next free entry
    logic [TAG_W:0]         count_q;  // One bit wider than pointers
    logic [QUEUE_DEPTH-1:0] valid_q;
    logic [QUEUE_DEPTH-1:0] done_q;
    logic [RD_W-1:0]        rd_q     [QUEUE_DEPTH];
    logic [DATA_W-1:0]      data_q   [QUEUE_DEPTH];
    status_t                status_q [QUEUE_DEPTH];
    logic                   res_hit;
    logic                   do_adv;

    assign res_hit = res_valid_i & valid_q[res_tag_i];  // Ignore stale tags
    assign do_adv  = advance_head_i & head_done_o;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            valid_q <= '0;
            done_q  <= '0;
        end else if (flush_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            valid_q <= '0;
            done_q  <= '0;
        end else begin
            if (alloc_i) begin
                valid_q[tail_q] <= 1'b1;
                done_q[tail_q]  <= alloc_illegal_i;
            end
            if (res_hit) begin
                done_q[res_tag_i] <= 1'b1;  // Out of order completion
            end
            if (do_adv) begin
                valid_q[head_q] <= 1'b0;
                done_q[head_q]  <= 1'b0;
            end
            head_q  <= head_q + TAG_W'(do_adv);
            tail_q  <= tail_q + TAG_W'(alloc_i);  // Wraps at the power of two
            count_q <= count_q + (TAG_W+1)'(alloc_i) - (TAG_W+1)'(do_adv);
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            rd_q[tail_q] <= alloc_rd_i;
            if (alloc_illegal_i) begin
                data_q[tail_q]   <= '0;
                status_q[tail_q] <= '{overflow: 1'b0, zero: 1'b0, illegal: 1'b1};
            end
        end
        if (res_hit) begin
            data_q[res_tag_i]   <= res_data_i;
            status_q[res_tag_i] <= res_status_i;
        end
    end

    assign tail_tag_o = tail_q;
    assign full_o     = (count_q == (TAG_W+1)'(QUEUE_DEPTH));

    // Head visible only once finished
    assign head_done_o   = valid_q[head_q] & done_q[head_q];
    assign head_rd_o     = head_done_o ? rd_q[head_q] : '0;
    assign head_data_o   = head_done_o ? data_q[head_q] : '0;
    assign head_status_o = head_done_o ? status_q[head_q] : '0;

endmodule

`default_nettype wire

// ==== hdl/writeback_stage.sv ====
// Output register of the arithmetic unit, presenting the oldest finished result under valid/ready
`timescale 1ns/1ps
`default_nettype none

module writeback_stage (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic                       flush_i,
    input  logic                       head_done_i,
    input  logic [mlu_pkg::RD_W-1:0]   head_rd_i,
    input  logic [mlu_pkg::DATA_W-1:0] head_data_i,
    input  mlu_pkg::status_t           head_status_i,
    input  logic                       out_ready_i,
    output logic                       advance_head_o,
    output logic                       out_valid_o,
    output logic [mlu_pkg::RD_W-1:0]   out_rd_o,
    output logic [mlu_pkg::DATA_W-1:0] out_data_o,
    output mlu_pkg::status_t           out_status_o
);
    logic load;

    // Take head when empty or draining this cycle
    assign load           = head_done_i & (~out_valid_o | out_ready_i);
    assign advance_head_o = load;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            out_valid_o <= 1'b0;
        end else if (flush_i) begin
            out_valid_o <= 1'b0;
        end else if (load) begin
            out_valid_o <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;  // Drained, nothing behind it
        end
    end

    // Held while stalled
    always_ff @(posedge clk_i) begin
        if (load) begin
            out_rd_o     <= head_rd_i;
            out_data_o   <= head_data_i;
            out_status_o <= head_status_i;
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
hdl/mlu_pkg.sv
hdl/op_decoder.sv
hdl/exec_pipes.sv
hdl/pending_ops_queue.sv
hdl/writeback_stage.sv
hdl/mlu_top.sv
bench/mlu_asserts.sv
bench/mlu_tb.sv
